//--- Bender.yml
package:
  name: mem_system

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/cache_pkg.sv
      - logic/mem_pkg.sv
      - logic/cache_store.sv
      - logic/four_bank_mem.sv
      - logic/mem_system.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_mem_system.sv

//--- flist.f
+incdir+include
logic/cache_pkg.sv
logic/mem_pkg.sv
logic/cache_store.sv
logic/four_bank_mem.sv
logic/mem_system.sv
test/tb_mem_system.sv

//--- include/mem_system_settings.svh
// Memory system settings

`ifndef MEM_SYSTEM_SETTINGS_SVH
`define MEM_SYSTEM_SETTINGS_SVH

////////////////////
// Data path widths
`define MS_ADDR_W 16
`define MS_DATA_W 16

////////////////////
// Cache geometry
// Tag plus index plus word plus byte bit fill the address
`define MS_TAG_W 5
`define MS_INDEX_W 8
`define MS_WORDS 4

////////////////////
// Main memory timing
// Read request to data valid
`define MS_MEM_RD_LAT 2
// Occupancy of a bank after each access
`define MS_BANK_BUSY 4

`endif

//--- logic/cache_pkg.sv
// Cache address package

`include "mem_system_settings.svh"

package cache_pkg;

   // Word select width inside one line
   localparam int unsigned OFFSET_W = $clog2(`MS_WORDS);

   // Processor address seen flat or as cache fields
   // Bit 0 selects a byte and is ignored
   typedef union packed {
      logic [`MS_ADDR_W-1:0] flat;
      struct packed {
         logic [`MS_TAG_W-1:0]   tag;
         logic [`MS_INDEX_W-1:0] index;
         logic [OFFSET_W-1:0]    word;
         logic                   byte_bit;
      } f;
   } cache_addr_u;

endpackage

//--- logic/cache_store.sv
// Direct-mapped cache arrays

`timescale 1ns/1ps

`include "mem_system_settings.svh"

module cache_store (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   enable,
   input  logic                   comp,
   input  logic                   write,
   input  logic                   valid_in,
   input  cache_pkg::cache_addr_u addr,
   input  logic [`MS_DATA_W-1:0]  wdata,
   output logic [`MS_DATA_W-1:0]  rdata,
   output logic [`MS_TAG_W-1:0]   tag_out,
   output logic                   hit,
   output logic                   dirty,
   output logic                   valid
);

   import cache_pkg::*;

   localparam int unsigned NLINES = 2 ** `MS_INDEX_W;
   localparam int unsigned NWORDS = NLINES * `MS_WORDS;

   ////////////////////
   // Arrays
   ////////////////////

   // Word storage addressed by index and word
   logic [`MS_DATA_W-1:0] data_mem [NWORDS];
   // One tag per line
   logic [`MS_TAG_W-1:0]  tag_mem [NLINES];
   // Line state bits
   logic [NLINES-1:0]     valid_bits;
   logic [NLINES-1:0]     dirty_bits;

   logic [`MS_INDEX_W-1:0]          line;
   logic [`MS_INDEX_W+OFFSET_W-1:0] word_sel;
   logic                            tag_match;
   logic                            line_hit;
   logic                            store_word;
   logic                            fill_line;

   assign line     = addr.f.index;
   assign word_sel = {addr.f.index, addr.f.word};

   ////////////////////
   // Lookup
   ////////////////////

   // Stored tag against the requested tag
   assign tag_match = (tag_mem[line] == addr.f.tag);
   assign line_hit  = valid_bits[line] && tag_match;

   // All read outputs settle in the same cycle
   assign rdata   = enable ? data_mem[word_sel] : '0;
   assign tag_out = tag_mem[line];
   assign valid   = valid_bits[line];
   assign dirty   = dirty_bits[line];
   // Hit only counts on a compare access
   assign hit     = enable && comp && line_hit;

   // Compare write lands only on a hit
   assign store_word = enable && write && (!comp || line_hit);
   // Non-compare write replaces tag and state
   assign fill_line  = enable && write && !comp;

   ////////////////////
   // Line state update
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (fill_line) begin
         // Fill leaves the line clean
         valid_bits[line] <= valid_in;
         dirty_bits[line] <= 1'b0;
      end else if (store_word) begin
         // Store hit marks the line for write-back
         dirty_bits[line] <= 1'b1;
      end
   end

   ////////////////////
   // Tag and data update
   ////////////////////

   always_ff @(posedge clk) begin
      if (store_word) begin
         data_mem[word_sel] <= wdata;
      end
      if (fill_line) begin
         tag_mem[line] <= addr.f.tag;
      end
   end

endmodule

//--- logic/four_bank_mem.sv
// Four-bank main memory model

`timescale 1ns/1ps

`include "mem_system_settings.svh"

module four_bank_mem (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  rd,
   input  logic                  wr,
   input  mem_pkg::mem_addr_u    addr,
   input  logic [`MS_DATA_W-1:0] wdata,
   output logic [`MS_DATA_W-1:0] rdata,
   output logic                  rdata_valid,
   output logic                  stall
);

   import mem_pkg::*;

   localparam int unsigned NBANKS = 2 ** BANK_W;
   localparam int unsigned NROWS  = 2 ** ROW_W;
   localparam int unsigned BUSY_W = $clog2(`MS_BANK_BUSY + 1);
   localparam int unsigned LAT    = `MS_MEM_RD_LAT;

   ////////////////////
   // Storage
   ////////////////////

   // Contents start at zero and survive reset
   logic [`MS_DATA_W-1:0] bank_mem [NBANKS][NROWS] = '{default: '0};

   // Cycles left before each bank takes a new access
   logic [BUSY_W-1:0]     busy_cnt [NBANKS];

   // Read pipeline, one entry per cycle of latency
   logic [LAT-1:0]        pipe_valid;
   logic [`MS_DATA_W-1:0] pipe_data [LAT];

   logic rd_accept;
   logic wr_accept;
   logic accept;

   ////////////////////
   // Bank arbitration
   ////////////////////

   // Busy addressed bank holds the command off
   assign stall = (rd || wr) && (busy_cnt[addr.f.bank] != '0);

   // Write wins if both are asserted
   assign wr_accept = wr && !stall;
   assign rd_accept = rd && !wr && !stall;
   assign accept    = rd_accept || wr_accept;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int b = 0; b < NBANKS; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < NBANKS; b++) begin
            if (accept && (addr.f.bank == BANK_W'(b))) begin
               // Fresh access reloads the occupancy
               busy_cnt[b] <= BUSY_W'(`MS_BANK_BUSY);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   ////////////////////
   // Array access
   ////////////////////

   always_ff @(posedge clk) begin
      if (wr_accept) begin
         bank_mem[addr.f.bank][addr.f.row] <= wdata;
      end
      // First stage picks up the addressed word
      pipe_data[0] <= bank_mem[addr.f.bank][addr.f.row];
      for (int s = 1; s < LAT; s++) begin
         pipe_data[s] <= pipe_data[s-1];
      end
   end

   ////////////////////
   // Read return
   ////////////////////

   // Valids shift with the data so several reads can be in flight
   always_ff @(posedge clk) begin
      if (reset) begin
         pipe_valid <= '0;
      end else begin
         pipe_valid[0] <= rd_accept;
         for (int s = 1; s < LAT; s++) begin
            pipe_valid[s] <= pipe_valid[s-1];
         end
      end
   end

   assign rdata       = pipe_data[LAT-1];
   assign rdata_valid = pipe_valid[LAT-1];

endmodule

//--- logic/mem_pkg.sv
// Main memory address package

`include "mem_system_settings.svh"

package mem_pkg;

   // Banks are picked by the word bits, so one line spans all banks
   localparam int unsigned BANK_W = $clog2(`MS_WORDS);
   // Row within a bank takes the rest above the bank bits
   localparam int unsigned ROW_W = `MS_ADDR_W - BANK_W - 1;

   // Memory address seen flat or as row and bank
   typedef union packed {
      logic [`MS_ADDR_W-1:0] flat;
      struct packed {
         logic [ROW_W-1:0]  row;
         logic [BANK_W-1:0] bank;
         logic              byte_bit;
      } f;
   } mem_addr_u;

endpackage

//--- logic/mem_system.sv
// Cached memory subsystem top

`timescale 1ns/1ps

`include "mem_system_settings.svh"

module mem_system (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   req,
   input  logic                   we,
   input  cache_pkg::cache_addr_u addr,
   input  logic [`MS_DATA_W-1:0]  wdata,
   output logic                   ack,
   output logic [`MS_DATA_W-1:0]  rdata,
   output logic                   hit
);

   import cache_pkg::*;
   import mem_pkg::*;

   // Word counter reaches MS_WORDS once all fill reads are out
   localparam int unsigned CNT_W = OFFSET_W + 1;
   localparam logic [OFFSET_W-1:0] LAST_WORD = OFFSET_W'(`MS_WORDS - 1);

   // Controller states
   localparam logic [2:0] S_IDLE    = 3'd0;
   localparam logic [2:0] S_LOOKUP  = 3'd1;
   localparam logic [2:0] S_WBACK   = 3'd2;
   localparam logic [2:0] S_FILL    = 3'd3;
   localparam logic [2:0] S_FINAL   = 3'd4;
   localparam logic [2:0] S_RESPOND = 3'd5;
   localparam logic [2:0] S_RELEASE = 3'd6;

   logic [2:0] state;

   // Request held for the whole access
   cache_addr_u           req_addr;
   logic [`MS_DATA_W-1:0] req_wdata;
   logic                  req_we;

   // Issue and return counters for line transfers
   logic [CNT_W-1:0]    word_cnt;
   logic [OFFSET_W-1:0] recv_cnt;

   // Line word at the issue counter under the new tag and the victim tag
   cache_addr_u           fill_addr;
   cache_addr_u           wb_addr;

   // Cache side
   logic                  cache_enable;
   logic                  cache_comp;
   logic                  cache_write;
   logic                  cache_valid_in;
   cache_addr_u           cache_addr;
   logic [`MS_DATA_W-1:0] cache_wdata;
   logic [`MS_DATA_W-1:0] cache_rdata;
   logic [`MS_TAG_W-1:0]  cache_tag;
   logic                  cache_hit;
   logic                  cache_dirty;
   logic                  cache_valid;

   // Memory side
   logic                  mem_rd;
   logic                  mem_wr;
   mem_addr_u             mem_addr;
   logic [`MS_DATA_W-1:0] mem_wdata;
   logic [`MS_DATA_W-1:0] mem_rdata;
   logic                  mem_rdata_valid;
   logic                  mem_stall;

   // Word address within a line with the byte bit cleared
   function automatic cache_addr_u word_addr(input logic [`MS_TAG_W-1:0]   tag,
                                             input logic [`MS_INDEX_W-1:0] index,
                                             input logic [OFFSET_W-1:0]    word);
      cache_addr_u a;
      a.f.tag      = tag;
      a.f.index    = index;
      a.f.word     = word;
      a.f.byte_bit = 1'b0;
      return a;
   endfunction

   cache_store cache (
      .clk      (clk),
      .reset    (reset),
      .enable   (cache_enable),
      .comp     (cache_comp),
      .write    (cache_write),
      .valid_in (cache_valid_in),
      .addr     (cache_addr),
      .wdata    (cache_wdata),
      .rdata    (cache_rdata),
      .tag_out  (cache_tag),
      .hit      (cache_hit),
      .dirty    (cache_dirty),
      .valid    (cache_valid)
   );

   four_bank_mem memory (
      .clk         (clk),
      .reset       (reset),
      .rd          (mem_rd),
      .wr          (mem_wr),
      .addr        (mem_addr),
      .wdata       (mem_wdata),
      .rdata       (mem_rdata),
      .rdata_valid (mem_rdata_valid),
      .stall       (mem_stall)
   );

   ////////////////////
   // Command decode
   ////////////////////

   assign fill_addr = word_addr(req_addr.f.tag, req_addr.f.index, word_cnt[OFFSET_W-1:0]);
   assign wb_addr   = word_addr(cache_tag, req_addr.f.index, word_cnt[OFFSET_W-1:0]);

   always_comb begin
      cache_enable   = 1'b0;
      cache_comp     = 1'b0;
      cache_write    = 1'b0;
      cache_valid_in = 1'b0;
      cache_addr     = req_addr;
      cache_wdata    = req_wdata;
      mem_rd         = 1'b0;
      mem_wr         = 1'b0;
      // Fill address by default at the counter's word
      mem_addr.flat  = fill_addr.flat;
      mem_wdata      = cache_rdata;
      case (state)
         S_LOOKUP, S_FINAL: begin
            // Compare access where a write stores on hit and sets dirty
            cache_enable = 1'b1;
            cache_comp   = 1'b1;
            cache_write  = req_we;
         end
         S_WBACK: begin
            // Victim word read out and sent to its old home
            cache_enable  = 1'b1;
            cache_addr    = fill_addr;
            mem_wr        = 1'b1;
            mem_addr.flat = wb_addr.flat;
         end
         S_FILL: begin
            // Issue reads until all words are out
            mem_rd         = (word_cnt != CNT_W'(`MS_WORDS));
            // Returned words land in order and leave the line clean
            cache_enable   = mem_rdata_valid;
            cache_write    = mem_rdata_valid;
            cache_valid_in = 1'b1;
            cache_addr     = word_addr(req_addr.f.tag, req_addr.f.index, recv_cnt);
            cache_wdata    = mem_rdata;
         end
         default: begin
            cache_enable = 1'b0;
         end
      endcase
   end

   ////////////////////
   // Miss FSM
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= S_IDLE;
         ack      <= 1'b0;
         hit      <= 1'b0;
         word_cnt <= '0;
         recv_cnt <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (req && !ack) begin
                  hit   <= 1'b0;
                  state <= S_LOOKUP;
               end
            end
            S_LOOKUP: begin
               word_cnt <= '0;
               recv_cnt <= '0;
               if (cache_hit) begin
                  hit   <= 1'b1;
                  state <= S_RESPOND;
               end else if (cache_valid && cache_dirty) begin
                  state <= S_WBACK;
               end else begin
                  state <= S_FILL;
               end
            end
            S_WBACK: begin
               // Counter frozen while the bank is busy
               if (!mem_stall) begin
                  if (word_cnt[OFFSET_W-1:0] == LAST_WORD) begin
                     word_cnt <= '0;
                     state    <= S_FILL;
                  end else begin
                     word_cnt <= word_cnt + 1'b1;
                  end
               end
            end
            S_FILL: begin
               if (mem_rd && !mem_stall) begin
                  word_cnt <= word_cnt + 1'b1;
               end
               if (mem_rdata_valid) begin
                  recv_cnt <= recv_cnt + 1'b1;
                  if (recv_cnt == LAST_WORD) begin
                     state <= S_FINAL;
                  end
               end
            end
            S_FINAL: begin
               state <= S_RESPOND;
            end
            S_RESPOND: begin
               ack   <= 1'b1;
               state <= S_RELEASE;
            end
            S_RELEASE: begin
               // Hold ack until the requester lets go
               if (!req) begin
                  ack   <= 1'b0;
                  state <= S_IDLE;
               end
            end
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   ////////////////////
   // Request and response data
   ////////////////////

   always_ff @(posedge clk) begin
      if ((state == S_IDLE) && req && !ack) begin
         req_addr  <= addr;
         req_wdata <= wdata;
         req_we    <= we;
      end
      // Read word from a hit or from the refilled line
      if (((state == S_LOOKUP) && cache_hit) || (state == S_FINAL)) begin
         rdata <= cache_rdata;
      end
   end

endmodule

//--- test/mem_stim.txt
# op addr wdata rdata hit, all hex, one access per line
# op 0 is a read and 1 a write, rdata is checked on reads only
0 0010 0000 0000 0
0 0012 0000 0000 1
1 0020 a5a5 0000 0
0 0020 0000 a5a5 1
0 0022 0000 0000 1
0 0024 0000 0000 1
0 0026 0000 0000 1
1 0024 1234 0000 1
1 0020 5a5a 0000 1
0 0020 0000 5a5a 1
0 0024 0000 1234 1
0 0820 0000 0000 0
0 0020 0000 5a5a 0
0 0024 0000 1234 1
1 0826 beef 0000 0
1 1026 cafe 0000 0
0 0826 0000 beef 0
0 1026 0000 cafe 0
0 0020 0000 5a5a 0
1 7ff8 0f0f 0000 0
1 7ffa 1111 0000 1
1 7ffc 2222 0000 1
1 7ffe 3333 0000 1
0 fff8 0000 0000 0
0 7ffe 0000 3333 0
0 7ffa 0000 1111 1
0 7ffb 0000 1111 1
1 0010 0001 0000 1
1 0812 0002 0000 0
1 1014 0003 0000 0
0 0010 0000 0001 0
0 0812 0000 0002 0
0 1014 0000 0003 0
0 1016 0000 0000 1
0 0000 0000 0000 0
0 0026 0000 0000 1
1 2a08 7777 0000 0
0 2a08 0000 7777 1
1 3208 8888 0000 0
0 2a08 0000 7777 0
0 3208 0000 8888 0
0 320a 0000 0000 1

//--- test/tb_mem_system.sv
// Memory system testbench

`timescale 1ns/1ps

`include "mem_system_settings.svh"

module tb_mem_system;

   localparam string STIM_FILE = "test/mem_stim.txt";
   // Cycle budget per stimulus line
   localparam int CYCLES_PER_ACCESS = 60;
   // Edges from the first edge seeing req up to ack on a hit
   localparam int HIT_EDGES = 3;

   logic                  clk;
   logic                  reset;
   logic                  req;
   logic                  we;
   logic [`MS_ADDR_W-1:0] addr;
   logic [`MS_DATA_W-1:0] wdata;
   logic                  ack;
   logic [`MS_DATA_W-1:0] rdata;
   logic                  hit;

   // Accesses read from the stimulus file
   logic                  st_we    [$];
   logic [`MS_ADDR_W-1:0] st_addr  [$];
   logic [`MS_DATA_W-1:0] st_wdata [$];
   logic [`MS_DATA_W-1:0] st_rdata [$];
   logic                  st_hit   [$];

   logic [31:0] lfsr;
   int          cycle_cnt   = 0;
   int          cycle_limit = CYCLES_PER_ACCESS;

   mem_system dut (
      .clk   (clk),
      .reset (reset),
      .req   (req),
      .we    (we),
      .addr  (addr),
      .wdata (wdata),
      .ack   (ack),
      .rdata (rdata),
      .hit   (hit)
   );

   always #2 clk = ~clk;

   ////////////////////
   // Timeout
   ////////////////////

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("Timeout after %0d cycles, the run hung waiting for ack", cycle_cnt);
         $display("Something failed");
         $fatal(1, "Cycle limit reached");
      end
   end

   ////////////////////
   // Helpers
   ////////////////////

   // Right-shift Galois LFSR with taps 32 31 29 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'hD000_0001;
      end
      return n;
   endfunction

   // One bit out per LFSR step
   task automatic take_bit(output logic b);
      b    = lfsr[0];
      lfsr = lfsr_next(lfsr);
   endtask

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("Error at %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
         $display("Something failed");
         $fatal(1, "Value mismatch");
      end
   endtask

   // Reads op, addr, wdata, rdata and hit per line
   // Comment lines fail the scan and are skipped
   task automatic load_stimulus();
      int                 fd;
      int                 rc;
      logic [31:0]        f_op;
      logic [31:0]        f_addr;
      logic [31:0]        f_wdata;
      logic [31:0]        f_rdata;
      logic [31:0]        f_hit;
      logic [8*128-1:0]   line;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file %s", STIM_FILE);
         $display("Something failed");
         $fatal(1, "No stimulus");
      end
      while (!$feof(fd)) begin
         rc = $fscanf(fd, "%h %h %h %h %h\n", f_op, f_addr, f_wdata, f_rdata, f_hit);
         if (rc == 5) begin
            st_we.push_back(f_op[0]);
            st_addr.push_back(f_addr[`MS_ADDR_W-1:0]);
            st_wdata.push_back(f_wdata[`MS_DATA_W-1:0]);
            st_rdata.push_back(f_rdata[`MS_DATA_W-1:0]);
            st_hit.push_back(f_hit[0]);
         end else begin
            // Rest of a comment line
            rc = $fgets(line, fd);
         end
      end
      $fclose(fd);
      if (st_addr.size() == 0) begin
         $display("The stimulus file holds no accesses");
         $display("Something failed");
         $fatal(1, "Empty stimulus");
      end
   endtask

   ////////////////////
   // Four-phase requester
   ////////////////////

   task automatic run_access(input int i);
      logic [1:0] hold;
      logic       b;
      int         edges;
      string      what;
      what = $sformatf("access %0d addr %h", i, st_addr[i]);
      req   = 1'b1;
      we    = st_we[i];
      addr  = st_addr[i];
      wdata = st_wdata[i];
      edges = 0;
      do begin
         @(posedge clk);
         #1;
         edges++;
      end while (!ack);
      // No ack before the earliest completion of a new request
      check_value(edges >= HIT_EDGES, 1'b1, $sformatf("%s no early ack", what));
      check_value(hit, st_hit[i], $sformatf("%s hit", what));
      if (!st_we[i]) begin
         check_value(rdata, st_rdata[i], $sformatf("%s rdata", what));
      end
      if (st_hit[i]) begin
         check_value(edges, HIT_EDGES, $sformatf("%s hit latency", what));
      end
      // Extra hold of 0 to 3 cycles
      take_bit(b);
      hold[0] = b;
      take_bit(b);
      hold[1] = b;
      repeat (hold) begin
         @(posedge clk);
         #1;
         check_value(ack, 1'b1, $sformatf("%s ack held with req", what));
      end
      req   = 1'b0;
      edges = 0;
      do begin
         @(posedge clk);
         #1;
         edges++;
      end while (ack);
      // Release takes exactly one edge
      check_value(edges, 1, $sformatf("%s ack release", what));
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      clk   = 1'b0;
      reset = 1'b1;
      req   = 1'b0;
      we    = 1'b0;
      addr  = '0;
      wdata = '0;
      lfsr  = 32'h7f26;
      load_stimulus();
      cycle_limit = st_addr.size() * CYCLES_PER_ACCESS;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      check_value(ack, 1'b0, "ack after reset");
      check_value(hit, 1'b0, "hit after reset");
      for (int i = 0; i < st_addr.size(); i++) begin
         run_access(i);
      end
      $display("Everything OK");
      $finish;
   end

endmodule
